// ==== Makefile ====
TOOL       = verilator
TOP        = tb_mrd_wht
FILELIST   = verilog.f
BUILD_DIR  = obj_dir
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Exit status of the run is the pass or fail result
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== design/mrd_bank_ram.sv ====
`include "mrd_settings.svh"

module mrd_bank_ram (
	input  logic              clk,
	input  mrd_pkg::ram_wr_t  wr,
	input  mrd_pkg::ram_rd_t  rd,
	output mrd_pkg::sample_t  q
);

	localparam int DEPTH = 1 << `MRD_BANK_ADDR_W;

	mrd_pkg::sample_t mem [DEPTH];

	// Write port
	always_ff @(posedge clk) begin
		if (wr.en) begin
			mem[wr.addr] <= wr.data;
		end
	end

	// Registered read, q holds between reads
	always_ff @(posedge clk) begin
		if (rd.en) begin
			q <= mem[rd.addr];
		end
	end

endmodule

// ==== design/mrd_butterfly.sv ====
`include "mrd_settings.svh"

module mrd_butterfly (
	input  logic                clk,
	input  logic                rst_n,
	input  mrd_pkg::bfly_pair_t in,
	output mrd_pkg::bfly_pair_t out
);

	logic                   valid_q;
	logic [`MRD_ADDR_W-1:0] addr_a_q;
	logic [`MRD_ADDR_W-1:0] addr_b_q;
	mrd_pkg::sample_t       sum_q;
	mrd_pkg::sample_t       dif_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= in.valid;
		end
	end

	// Radix-2 core, no twiddle
	always_ff @(posedge clk) begin
		addr_a_q  <= in.addr_a;
		addr_b_q  <= in.addr_b;
		sum_q.re  <= in.a.re + in.b.re;
		sum_q.im  <= in.a.im + in.b.im;
		dif_q.re  <= in.a.re - in.b.re;
		dif_q.im  <= in.a.im - in.b.im;
	end

	// Sum back to addr_a, difference to addr_b
	assign out = '{valid: valid_q, addr_a: addr_a_q, addr_b: addr_b_q, a: sum_q, b: dif_q};

endmodule

// ==== design/mrd_mem_top.sv ====
`include "mrd_settings.svh"

module mrd_mem_top (
	input  logic                clk,
	input  logic                rst_n,
	input  mrd_pkg::in_beat_t   in,
	output mrd_pkg::bfly_pair_t rd_pair,
	input  mrd_pkg::bfly_pair_t wr_pair,
	output mrd_pkg::out_beat_t  out,
	output mrd_pkg::mem_state_e fsm,
	output logic                sink_ready
);

	localparam int WD_W = `MRD_WATCHDOG_W;

	mrd_pkg::mem_state_e fsm_next;
	mrd_pkg::mem_state_e fsm_r;
	logic [2:0]          size;
	logic [2:0]          cnt_stage;
	logic                accept_sop;
	logic                sink_active;
	logic                sink_done;
	logic                overtime;
	logic                rd_start;
	logic                src_start;
	logic                rd_end;
	logic                wr_end;
	logic                source_end;
	logic [WD_W-1:0]     cnt_watchdog;
	logic                watchdog;
	mrd_pkg::ram_wr_t    sink_wr0, sink_wr1;
	mrd_pkg::ram_wr_t    stage_wr0, stage_wr1;
	mrd_pkg::ram_rd_t    stage_rd0, stage_rd1;
	mrd_pkg::ram_rd_t    src_rd0, src_rd1;
	mrd_pkg::ram_wr_t    bank_wr0, bank_wr1;
	mrd_pkg::ram_rd_t    bank_rd0, bank_rd1;
	mrd_pkg::sample_t    q0, q1;

	// Sink opens on an accepted sop
	assign accept_sop  = sink_ready & in.valid & in.sop;
	assign sink_active = (fsm == mrd_pkg::SINK) | accept_sop;

	// ------------------------------
	// FSM
	// ------------------------------
	always_comb begin
		fsm_next = fsm;
		if (watchdog) begin
			fsm_next = mrd_pkg::IDLE;
		end else begin
			case (fsm)
				mrd_pkg::IDLE: begin
					if (accept_sop) fsm_next = mrd_pkg::SINK;
				end
				mrd_pkg::SINK: begin
					if (sink_done) fsm_next = mrd_pkg::RD;
					else if (overtime) fsm_next = mrd_pkg::IDLE;
				end
				mrd_pkg::RD: begin
					if (rd_end) fsm_next = mrd_pkg::WAIT_WR_END;
				end
				mrd_pkg::WAIT_WR_END: begin
					// Last stage is size-1
					if (wr_end) begin
						fsm_next = (cnt_stage == size - 3'd1) ? mrd_pkg::SOURCE : mrd_pkg::RD;
					end
				end
				mrd_pkg::SOURCE: begin
					if (source_end) fsm_next = mrd_pkg::IDLE;
				end
				default: fsm_next = mrd_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fsm        <= mrd_pkg::IDLE;
			fsm_r      <= mrd_pkg::IDLE;
			sink_ready <= 1'b0;
			cnt_stage  <= '0;
		end else begin
			fsm        <= fsm_next;
			fsm_r      <= fsm;
			// Drops in the cycle the packet is taken
			sink_ready <= (fsm_next == mrd_pkg::IDLE);
			if (fsm == mrd_pkg::IDLE) begin
				cnt_stage <= '0;
			end else if (fsm == mrd_pkg::WAIT_WR_END && wr_end) begin
				cnt_stage <= cnt_stage + 3'd1;
			end
		end
	end

	// Watchdog, any stay outside IDLE
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt_watchdog <= '0;
			watchdog     <= 1'b0;
		end else begin
			cnt_watchdog <= (fsm == mrd_pkg::IDLE) ? '0 : cnt_watchdog + WD_W'(1);
			watchdog     <= (cnt_watchdog == '1);
		end
	end

	// Start pulses on state entry
	assign rd_start  = (fsm == mrd_pkg::RD) & (fsm_r != mrd_pkg::RD);
	assign src_start = (fsm == mrd_pkg::SOURCE) & (fsm_r != mrd_pkg::SOURCE);

	// ------------------------------
	// Bank switches
	// ------------------------------
	always_comb begin
		case (fsm)
			mrd_pkg::SINK: begin
				bank_wr0 = sink_wr0;
				bank_wr1 = sink_wr1;
			end
			mrd_pkg::RD, mrd_pkg::WAIT_WR_END: begin
				bank_wr0 = stage_wr0;
				bank_wr1 = stage_wr1;
			end
			default: begin
				bank_wr0 = '0;
				bank_wr1 = '0;
			end
		endcase
		case (fsm)
			mrd_pkg::RD: begin
				bank_rd0 = stage_rd0;
				bank_rd1 = stage_rd1;
			end
			mrd_pkg::SOURCE: begin
				bank_rd0 = src_rd0;
				bank_rd1 = src_rd1;
			end
			default: begin
				bank_rd0 = '0;
				bank_rd1 = '0;
			end
		endcase
	end

	// Even parity bank
	mrd_bank_ram u_bank0 (.clk(clk), .wr(bank_wr0), .rd(bank_rd0), .q(q0));
	// Odd parity bank
	mrd_bank_ram u_bank1 (.clk(clk), .wr(bank_wr1), .rd(bank_rd1), .q(q1));

	// ------------------------------
	// Sequencers
	// ------------------------------
	mrd_sink_ctrl u_sink (
		.clk(clk), .rst_n(rst_n), .active(sink_active), .in(in),
		.wr0(sink_wr0), .wr1(sink_wr1), .size(size),
		.done(sink_done), .overtime(overtime)
	);

	mrd_stage_rd u_stage_rd (
		.clk(clk), .rst_n(rst_n), .start(rd_start), .stage(cnt_stage), .size(size),
		.rd0(stage_rd0), .rd1(stage_rd1), .pair(rd_pair),
		.q0(q0), .q1(q1), .rd_end(rd_end)
	);

	mrd_stage_wr u_stage_wr (
		.clk(clk), .rst_n(rst_n), .start(rd_start), .size(size), .pair(wr_pair),
		.wr0(stage_wr0), .wr1(stage_wr1), .wr_end(wr_end)
	);

	mrd_source_ctrl u_source (
		.clk(clk), .rst_n(rst_n), .start(src_start), .size(size),
		.rd0(src_rd0), .rd1(src_rd1), .q0(q0), .q1(q1),
		.out(out), .source_end(source_end)
	);

endmodule

// ==== design/mrd_pkg.sv ====
`include "mrd_settings.svh"

package mrd_pkg;

	// Complex sample as stored in the banks
	typedef struct packed {
		logic signed [`MRD_DATA_W-1:0] re;
		logic signed [`MRD_DATA_W-1:0] im;
	} sample_t;

	// Input beat, size is log2 of the point count
	typedef struct packed {
		logic                        valid;
		logic                        sop;
		logic [2:0]                  size;
		logic signed [`MRD_IN_W-1:0] re;
		logic signed [`MRD_IN_W-1:0] im;
	} in_beat_t;

	// Output beat
	typedef struct packed {
		logic    valid;
		logic    sop;
		logic    eop;
		sample_t data;
	} out_beat_t;

	// Butterfly operands or results with their point addresses
	typedef struct packed {
		logic                   valid;
		logic [`MRD_ADDR_W-1:0] addr_a;
		logic [`MRD_ADDR_W-1:0] addr_b;
		sample_t                a;
		sample_t                b;
	} bfly_pair_t;

	// Bank write port
	typedef struct packed {
		logic                        en;
		logic [`MRD_BANK_ADDR_W-1:0] addr;
		sample_t                     data;
	} ram_wr_t;

	// Bank read port
	typedef struct packed {
		logic                        en;
		logic [`MRD_BANK_ADDR_W-1:0] addr;
	} ram_rd_t;

	typedef enum logic [2:0] {
		IDLE,
		SINK,
		RD,
		WAIT_WR_END,
		SOURCE
	} mem_state_e;

endpackage

// ==== design/mrd_settings.svh ====
`ifndef MRD_SETTINGS_SVH
`define MRD_SETTINGS_SVH

// Input sample component width
`define MRD_IN_W 12

// Stored and output component width
// 12 input bits plus one bit of growth per stage, up to 6 stages
`define MRD_DATA_W 18

// Point address, 64 points max
`define MRD_ADDR_W 6

// Address inside one bank, 32 entries per bank
`define MRD_BANK_ADDR_W 5

// Idle input cycles tolerated in sink before abort
`define MRD_OVERTIME 64

// Watchdog counter width
`define MRD_WATCHDOG_W 14

`endif

// ==== design/mrd_sink_ctrl.sv ====
`include "mrd_settings.svh"

module mrd_sink_ctrl (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              active,
	input  mrd_pkg::in_beat_t in,
	output mrd_pkg::ram_wr_t  wr0,
	output mrd_pkg::ram_wr_t  wr1,
	output logic [2:0]        size,
	output logic              done,
	output logic              overtime
);

	localparam int AW   = `MRD_ADDR_W;
	localparam int OT_W = $clog2(`MRD_OVERTIME + 1);

	logic                         running;
	logic [AW-1:0]                cnt;
	logic [AW-1:0]                p;
	logic [AW-1:0]                last_idx;
	logic [2:0]                   size_q;
	logic [2:0]                   size_cur;
	logic                         first;
	logic                         take;
	logic                         last;
	logic [OT_W-1:0]              idle_cnt;
	logic                         wr_en_q;
	logic                         done_q;
	logic                         bank_q;
	logic [`MRD_BANK_ADDR_W-1:0]  addr_q;
	mrd_pkg::sample_t             data_q;

	// sop opens a packet, later sops are plain data
	assign first    = active & in.valid & in.sop & ~running;
	assign take     = active & in.valid & (running | in.sop);
	assign size_cur = first ? in.size : size_q;
	assign p        = first ? '0 : cnt;
	// All ones below bit size, wraps to 63 for 64 points
	assign last_idx = (AW'(1) << size_cur) - AW'(1);
	assign last     = take & (p == last_idx);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			running  <= 1'b0;
			cnt      <= '0;
			size_q   <= '0;
			idle_cnt <= '0;
			wr_en_q  <= 1'b0;
			done_q   <= 1'b0;
		end else begin
			// Abort closes the packet as well
			if (!active || last || overtime) begin
				running <= 1'b0;
			end else if (first) begin
				running <= 1'b1;
			end
			if (take) begin
				cnt <= p + AW'(1);
			end
			if (first) begin
				size_q <= in.size;
			end
			// Consecutive invalid cycles only
			idle_cnt <= (!active || in.valid) ? '0 : idle_cnt + OT_W'(1);
			wr_en_q  <= take;
			done_q   <= last;
		end
	end

	// Sample and its bank slot, written next cycle
	always_ff @(posedge clk) begin
		if (take) begin
			bank_q    <= ^p;
			addr_q    <= p[AW-1:1];
			data_q.re <= `MRD_DATA_W'(in.re);
			data_q.im <= `MRD_DATA_W'(in.im);
		end
	end

	// Parity picks the bank
	assign wr0 = '{en: wr_en_q & ~bank_q, addr: addr_q, data: data_q};
	assign wr1 = '{en: wr_en_q & bank_q, addr: addr_q, data: data_q};

	assign size     = size_q;
	assign done     = done_q;
	assign overtime = (idle_cnt == OT_W'(`MRD_OVERTIME));

endmodule

// ==== design/mrd_source_ctrl.sv ====
`include "mrd_settings.svh"

module mrd_source_ctrl (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	input  logic [2:0]         size,
	output mrd_pkg::ram_rd_t   rd0,
	output mrd_pkg::ram_rd_t   rd1,
	input  mrd_pkg::sample_t   q0,
	input  mrd_pkg::sample_t   q1,
	output mrd_pkg::out_beat_t out,
	output logic               source_end
);

	localparam int AW = `MRD_ADDR_W;

	logic             running;
	logic [AW-1:0]    p;
	logic [AW-1:0]    p_last;
	logic             last;
	logic             bank;
	logic             v_q;
	logic             sop_q;
	logic             eop_q;
	logic             sel_q;
	logic             out_valid;
	logic             out_sop;
	logic             out_eop;
	mrd_pkg::sample_t out_data;

	assign p_last = (AW'(1) << size) - AW'(1);
	assign last   = running & (p == p_last);
	assign bank   = ^p;

	// Natural order, one point per cycle
	assign rd0 = '{en: running & ~bank, addr: p[AW-1:1]};
	assign rd1 = '{en: running & bank, addr: p[AW-1:1]};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			running   <= 1'b0;
			p         <= '0;
			v_q       <= 1'b0;
			sop_q     <= 1'b0;
			eop_q     <= 1'b0;
			out_valid <= 1'b0;
			out_sop   <= 1'b0;
			out_eop   <= 1'b0;
		end else begin
			if (start) begin
				running <= 1'b1;
				p       <= '0;
			end else if (running) begin
				running <= ~last;
				p       <= p + AW'(1);
			end
			// Framing waits for the RAM read
			v_q       <= running;
			sop_q     <= running & (p == '0);
			eop_q     <= last;
			out_valid <= v_q;
			out_sop   <= sop_q;
			out_eop   <= eop_q;
		end
	end

	// Bank select delayed with the read
	always_ff @(posedge clk) begin
		sel_q    <= bank;
		out_data <= sel_q ? q1 : q0;
	end

	assign out = '{valid: out_valid, sop: out_sop, eop: out_eop, data: out_data};

	assign source_end = out_valid & out_eop;

endmodule

// ==== design/mrd_stage_rd.sv ====
`include "mrd_settings.svh"

module mrd_stage_rd (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  logic [2:0]          stage,
	input  logic [2:0]          size,
	output mrd_pkg::ram_rd_t    rd0,
	output mrd_pkg::ram_rd_t    rd1,
	output mrd_pkg::bfly_pair_t pair,
	input  mrd_pkg::sample_t    q0,
	input  mrd_pkg::sample_t    q1,
	output logic                rd_end
);

	localparam int AW = `MRD_ADDR_W;

	logic          running;
	logic [AW-2:0] j;
	logic [AW-2:0] j_last;
	logic [AW-1:0] j_ext;
	logic [AW-1:0] low_mask;
	logic [AW-1:0] addr_a;
	logic [AW-1:0] addr_b;
	logic          bank_a;
	logic          last;
	logic          valid_q;
	logic          bank_a_q;
	logic [AW-1:0] addr_a_q;
	logic [AW-1:0] addr_b_q;

	// ------------------------------
	// Pair addresses
	// ------------------------------
	// Half the points per stage
	assign j_last   = (AW-1)'((AW'(1) << (size - 3'd1)) - AW'(1));
	assign j_ext    = AW'(j);
	assign low_mask = (AW'(1) << stage) - AW'(1);
	// Zero inserted at bit stage
	assign addr_a   = ((j_ext & ~low_mask) << 1) | (j_ext & low_mask);
	assign addr_b   = addr_a | (AW'(1) << stage);
	// Partners differ in one bit, so never share a bank
	assign bank_a   = ^addr_a;
	assign last     = running & (j == j_last);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			running <= 1'b0;
			j       <= '0;
			rd_end  <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			if (start) begin
				running <= 1'b1;
				j       <= '0;
			end else if (running) begin
				running <= ~last;
				j       <= j + (AW-1)'(1);
			end
			rd_end  <= last;
			valid_q <= running;
		end
	end

	// Both banks read in the same cycle
	assign rd0 = '{en: running, addr: bank_a ? addr_b[AW-1:1] : addr_a[AW-1:1]};
	assign rd1 = '{en: running, addr: bank_a ? addr_a[AW-1:1] : addr_b[AW-1:1]};

	// ------------------------------
	// Operand assembly
	// ------------------------------
	// Addresses follow the RAM read latency
	always_ff @(posedge clk) begin
		bank_a_q <= bank_a;
		addr_a_q <= addr_a;
		addr_b_q <= addr_b;
	end

	// a from the bank of addr_a
	assign pair = '{
		valid:  valid_q,
		addr_a: addr_a_q,
		addr_b: addr_b_q,
		a:      bank_a_q ? q1 : q0,
		b:      bank_a_q ? q0 : q1
	};

endmodule

// ==== design/mrd_stage_wr.sv ====
`include "mrd_settings.svh"

module mrd_stage_wr (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  logic [2:0]          size,
	input  mrd_pkg::bfly_pair_t pair,
	output mrd_pkg::ram_wr_t    wr0,
	output mrd_pkg::ram_wr_t    wr1,
	output logic                wr_end
);

	localparam int AW = `MRD_ADDR_W;

	logic [AW-2:0] cnt;
	logic [AW-2:0] cnt_last;
	logic          bank_a;

	assign cnt_last = (AW-1)'((AW'(1) << (size - 3'd1)) - AW'(1));
	assign bank_a   = ^pair.addr_a;

	// Results counted per stage
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt    <= '0;
			wr_end <= 1'b0;
		end else begin
			if (start) begin
				cnt <= '0;
			end else if (pair.valid) begin
				cnt <= cnt + (AW-1)'(1);
			end
			wr_end <= pair.valid & ~start & (cnt == cnt_last);
		end
	end

	// In place, each result to its parity bank
	assign wr0 = '{
		en:   pair.valid,
		addr: bank_a ? pair.addr_b[AW-1:1] : pair.addr_a[AW-1:1],
		data: bank_a ? pair.b : pair.a
	};
	assign wr1 = '{
		en:   pair.valid,
		addr: bank_a ? pair.addr_a[AW-1:1] : pair.addr_b[AW-1:1],
		data: bank_a ? pair.a : pair.b
	};

endmodule

// ==== design/mrd_wht_top.sv ====
module mrd_wht_top (
	input  logic                clk,
	input  logic                rst_n,
	input  mrd_pkg::in_beat_t   in,
	output mrd_pkg::out_beat_t  out,
	output mrd_pkg::mem_state_e fsm,
	output logic                sink_ready
);

	// Operands out of the banks, results back in
	mrd_pkg::bfly_pair_t rd_pair;
	mrd_pkg::bfly_pair_t wr_pair;

	mrd_mem_top u_mem (
		.clk        (clk),
		.rst_n      (rst_n),
		.in         (in),
		.rd_pair    (rd_pair),
		.wr_pair    (wr_pair),
		.out        (out),
		.fsm        (fsm),
		.sink_ready (sink_ready)
	);

	// One pair per cycle, pipelined
	mrd_butterfly u_bfly (
		.clk   (clk),
		.rst_n (rst_n),
		.in    (rd_pair),
		.out   (wr_pair)
	);

endmodule

// ==== tb/mrd_wht_model.svh ====
`ifndef MRD_WHT_MODEL_SVH
`define MRD_WHT_MODEL_SVH

// ------------------------------
// Reference model
// ------------------------------

// Samples of the packet being sent, sign extended
int src_re [64];
int src_im [64];

// Expected output beats, oldest first
mrd_pkg::out_beat_t exp_q[$];

// Number of ones in a point index
function automatic int ones_in(input int v);
	int n;
	int b;
	n = 0;
	for (b = 0; b < `MRD_ADDR_W; b++) begin
		n += (v >> b) & 1;
	end
	return n;
endfunction

// Unnormalized complex Walsh-Hadamard, natural order
task automatic push_expected(input int size_log2);
	int                 points;
	int                 k;
	int                 n;
	int                 acc_re;
	int                 acc_im;
	mrd_pkg::out_beat_t beat;
	points = 1 << size_log2;
	for (k = 0; k < points; k++) begin
		acc_re = 0;
		acc_im = 0;
		for (n = 0; n < points; n++) begin
			// Sign from parity of shared index bits
			if (ones_in(n & k) % 2 == 0) begin
				acc_re += src_re[n];
				acc_im += src_im[n];
			end else begin
				acc_re -= src_re[n];
				acc_im -= src_im[n];
			end
		end
		beat         = '0;
		beat.valid   = 1'b1;
		beat.sop     = (k == 0);
		beat.eop     = (k == points - 1);
		// At most 6 bits of growth, always fits
		beat.data.re = `MRD_DATA_W'(acc_re);
		beat.data.im = `MRD_DATA_W'(acc_im);
		exp_q.push_back(beat);
	end
endtask

`endif

// ==== tb/tb_mrd_wht.sv ====
`include "mrd_settings.svh"

module tb_mrd_wht;

	localparam int DRIVE_DLY   = 1;
	localparam int READY_LIMIT = 2 * `MRD_OVERTIME + 16;
	localparam int EOP_LIMIT   = 4000;

	logic                clk;
	logic                rst_n;
	mrd_pkg::in_beat_t   in;
	mrd_pkg::out_beat_t  out;
	mrd_pkg::mem_state_e fsm;
	logic                sink_ready;

	integer seed        = 32'h58c6_04bb;
	int     error_count = 0;
	// Monitor is between sop and eop
	bit     in_pkt      = 1'b0;
	bit     ready_armed = 1'b0;
	// Packet accepted and not yet finished or abandoned
	bit     pkt_open    = 1'b0;

	`include "mrd_wht_model.svh"

	mrd_wht_top u_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.in         (in),
		.out        (out),
		.fsm        (fsm),
		.sink_ready (sink_ready)
	);

	// Period 4
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ------------------------------
	// Helpers
	// ------------------------------
	task automatic abort_run();
		$display("sim failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input int actual, input int expected, input string what);
		if (actual !== expected) begin
			error_count++;
			$display("FAILED at time %0t: %s, got %0d, expected %0d",
				$time, what, actual, expected);
			abort_run();
		end
	endtask

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// Inputs change just after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic drive_idle(input int cycles);
		in = '0;
		repeat (cycles) next_cycle();
	endtask

	task automatic drive_beat(input bit sop, input int size_log2, input int re, input int im);
		in.valid = 1'b1;
		in.sop   = sop;
		in.size  = 3'(size_log2);
		in.re    = 12'(re);
		in.im    = 12'(im);
		next_cycle();
		in = '0;
	endtask

	// Mostly short gaps, sometimes close to overtime
	function automatic int pick_gap();
		if (rand_below(16) == 0) begin
			return `MRD_OVERTIME - 4 - rand_below(20);
		end
		return rand_below(2);
	endfunction

	task automatic wait_ready();
		int n;
		n = 0;
		while (sink_ready !== 1'b1) begin
			if (n == READY_LIMIT) begin
				$display("Timeout, sink_ready stayed low for %0d cycles", READY_LIMIT);
				abort_run();
			end
			next_cycle();
			n++;
		end
	endtask

	task automatic wait_eop();
		int n;
		n = 0;
		while (!(out.valid === 1'b1 && out.eop === 1'b1)) begin
			if (n == EOP_LIMIT) begin
				$display("Timeout, no end of output packet within %0d cycles", EOP_LIMIT);
				abort_run();
			end
			next_cycle();
			n++;
		end
		next_cycle();
	endtask

	// ------------------------------
	// Packet driver
	// ------------------------------
	// Sends the first beats of a packet, model only for a full one
	task automatic send_packet(input int size_log2, input int beats);
		int          points;
		int          i;
		logic [11:0] r;
		points = 1 << size_log2;
		for (i = 0; i < points; i++) begin
			r         = 12'($random(seed));
			src_re[i] = int'($signed(r));
			r         = 12'($random(seed));
			src_im[i] = int'($signed(r));
		end
		wait_ready();
		for (i = 0; i < beats; i++) begin
			if (i > 0) begin
				drive_idle(pick_gap());
			end
			drive_beat(i == 0, size_log2, src_re[i], src_im[i]);
			// sop taken at the edge just passed
			if (i == 0) begin
				pkt_open = 1'b1;
			end
		end
		if (beats == points) begin
			push_expected(size_log2);
		end
	endtask

	// Beats while sink_ready is low, must be ignored
	task automatic offer_junk(input int cycles);
		repeat (cycles) begin
			in.valid = 1'b1;
			in.sop   = 1'($random(seed));
			in.size  = 3'($random(seed));
			in.re    = 12'($random(seed));
			in.im    = 12'($random(seed));
			next_cycle();
		end
		in = '0;
	endtask

	task automatic run_full(input int size_log2);
		send_packet(size_log2, 1 << size_log2);
		// Sink has left SINK after these
		drive_idle(3);
		offer_junk(2 + rand_below(6));
		wait_eop();
	endtask

	// Partial packet, then silence until overtime
	task automatic run_abort(input int size_log2);
		send_packet(size_log2, 1 + rand_below((1 << size_log2) - 1));
		wait_ready();
		pkt_open = 1'b0;
	endtask

	// ------------------------------
	// Stimulus
	// ------------------------------
	initial begin : stimulus
		int k;
		int sz;
		in    = '0;
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b1;
		// Every size once
		for (sz = 3; sz <= 6; sz++) begin
			run_full(sz);
		end
		// Abort, then a clean packet
		run_abort(3 + rand_below(4));
		run_full(3 + rand_below(4));
		// Random mix
		for (k = 0; k < 12; k++) begin
			if (rand_below(4) == 0) begin
				run_abort(3 + rand_below(4));
			end
			run_full(3 + rand_below(4));
		end
		// Quiet tail, nothing more may come out
		drive_idle(40);
		check_value(exp_q.size(), 0, "expected beats left over");
		if (error_count == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			abort_run();
		end
	end

	// ------------------------------
	// Output monitor
	// ------------------------------
	// Samples at the falling edge, outputs settled
	initial begin : monitor
		mrd_pkg::out_beat_t want;
		forever begin
			@(negedge clk);
			if (rst_n) begin
				// Ready and IDLE only outside a packet, from the second cycle on
				if (ready_armed) begin
					check_value(int'(sink_ready), int'(!pkt_open),
						"sink_ready outside a packet");
					check_value(int'(fsm == mrd_pkg::IDLE), int'(!pkt_open),
						"IDLE state outside a packet");
				end
				ready_armed = 1'b1;
				if (out.valid) begin
					check_value(exp_q.size() > 0 ? 1 : 0, 1,
						"valid output with no packet pending");
					want = exp_q.pop_front();
					check_value(int'(fsm == mrd_pkg::SOURCE), 1, "state SOURCE during output");
					check_value(int'(out.sop), int'(want.sop), "output sop");
					check_value(int'(out.eop), int'(want.eop), "output eop");
					check_value(int'($signed(out.data.re)), int'($signed(want.data.re)),
						"output re");
					check_value(int'($signed(out.data.im)), int'($signed(want.data.im)),
						"output im");
					in_pkt = !out.eop;
					// Ready returns one cycle after eop
					if (out.eop) begin
						pkt_open = 1'b0;
					end
				end else begin
					// Beats are contiguous
					check_value(int'(in_pkt), 0, "gap inside output packet");
					check_value(int'(out.sop | out.eop), 0, "sop or eop without valid");
				end
			end
		end
	end

endmodule

// ==== verilog.f ====
+incdir+design
+incdir+tb
design/mrd_pkg.sv
design/mrd_bank_ram.sv
design/mrd_sink_ctrl.sv
design/mrd_stage_rd.sv
design/mrd_butterfly.sv
design/mrd_stage_wr.sv
design/mrd_source_ctrl.sv
design/mrd_mem_top.sv
design/mrd_wht_top.sv
tb/tb_mrd_wht.sv
